// File: dv/aesRefModel.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

`default_nettype none

// Product in GF(2^8), peasant style
function automatic aesPkg::aesByteT refMul(
    input aesPkg::aesByteT a,
    input aesPkg::aesByteT b
);
    aesPkg::aesByteT x;
    aesPkg::aesByteT y;
    aesPkg::aesByteT p;
    x = a;
    y = b;
    p = 8'h00;
    while (y != 8'h00) begin
        if (y[0]) begin
            p = p ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        y = {1'b0, y[7:1]};
    end
    return p;
endfunction

// S-box from an exhaustive inverse search and the bitwise affine map
function automatic aesPkg::aesByteT refSub(input aesPkg::aesByteT a);
    aesPkg::aesByteT inv;
    aesPkg::aesByteT res;
    aesPkg::aesByteT c;
    inv = 8'h00;
    c   = 8'h63;
    for (int i = 1; i < 256; i++) begin
        if (a != 8'h00 && refMul(a, i[7:0]) == 8'h01) begin
            inv = i[7:0];
        end
    end
    for (int j = 0; j < 8; j++) begin
        res[j] = inv[j] ^ inv[(j+4)%8] ^ inv[(j+5)%8] ^ inv[(j+6)%8] ^ inv[(j+7)%8] ^ c[j];
    end
    return res;
endfunction

// Byte n of a block is row n%4 of column n/4
function automatic aesPkg::aesBlockT aesEncrypt(
    input aesPkg::aesBlockT plain,
    input aesPkg::aesBlockT key
);
    aesPkg::aesByteT  st  [16];
    aesPkg::aesByteT  tmp [16];
    aesPkg::aesByteT  rk  [16];
    aesPkg::aesByteT  kw  [4];
    aesPkg::aesByteT  col [4];
    aesPkg::aesByteT  rc;
    aesPkg::aesBlockT result;
    for (int n = 0; n < 16; n++) begin
        rk[n] = key[127-8*n -: 8];
        st[n] = plain[127-8*n -: 8] ^ rk[n];
    end
    rc = 8'h01;
    for (int round = 1; round <= 10; round++) begin
        // Next round key
        kw[0] = refSub(rk[13]) ^ rc;
        kw[1] = refSub(rk[14]);
        kw[2] = refSub(rk[15]);
        kw[3] = refSub(rk[12]);
        for (int n = 0; n < 4; n++) begin
            rk[n] = rk[n] ^ kw[n];
        end
        for (int n = 4; n < 16; n++) begin
            rk[n] = rk[n] ^ rk[n-4];
        end
        rc = refMul(rc, 8'h02);
        // SubBytes with row r shifted left by r columns
        for (int n = 0; n < 16; n++) begin
            tmp[n] = refSub(st[(n%4) + 4*(((n/4) + (n%4)) % 4)]);
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                col[r] = tmp[4*c + r];
            end
            if (round < 10) begin
                tmp[4*c]     = refMul(col[0], 8'h02) ^ refMul(col[1], 8'h03) ^ col[2] ^ col[3];
                tmp[4*c + 1] = col[0] ^ refMul(col[1], 8'h02) ^ refMul(col[2], 8'h03) ^ col[3];
                tmp[4*c + 2] = col[0] ^ col[1] ^ refMul(col[2], 8'h02) ^ refMul(col[3], 8'h03);
                tmp[4*c + 3] = refMul(col[0], 8'h03) ^ col[1] ^ col[2] ^ refMul(col[3], 8'h02);
            end
        end
        for (int n = 0; n < 16; n++) begin
            st[n] = tmp[n] ^ rk[n];
        end
    end
    for (int n = 0; n < 16; n++) begin
        result[127-8*n -: 8] = st[n];
    end
    return result;
endfunction

`default_nettype wire

`endif

// File: dv/aesCipherTb.sv
`include "aesRefModel.svh"

`default_nettype none
`timescale 1ns/100ps

module aesCipherTb;
    import aesPkg::*;

    // Cycles from the one that presents inValid to the one that shows outValid
    localparam int expLatency = 21;

    logic     clk;
    logic     Baud8GeneratorACC;
    logic     inValid;
    aesBlockT plainText;
    aesBlockT cipherKey;
    logic     outValid;
    aesBlockT cipherText;

    aesBlockT expQ [$];
    int       dueQ [$];
    int       cycle = 0;
    integer   seed;
    string    testName;

    aesCipherTop u_aesCipherTop (
        .clk               (clk),
        .Baud8GeneratorACC (Baud8GeneratorACC),
        .inValid           (inValid),
        .plainText         (plainText),
        .cipherKey         (cipherKey),
        .outValid          (outValid),
        .cipherText        (cipherText)
    );

    always begin
        #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////
    // Reporting and checks
    //////////////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValue(input string label, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", label, expected, actual);
            failRun("Stopping at first mismatch");
        end
    endtask

    // Scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
                failRun($sformatf("outValid high in %s with no block in flight", testName));
            end else begin
                checkValue({testName, " latency"}, 128'(dueQ.pop_front()), 128'(cycle));
                checkValue({testName, " ciphertext"}, expQ.pop_front(), cipherText);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic aesBlockT randomBlock();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic sendBlock(input aesBlockT pt, input aesBlockT key);
        @(posedge clk);
        #1;
        inValid   = 1'b1;
        plainText = pt;
        cipherKey = key;
        expQ.push_back(aesEncrypt(pt, key));
        // Seen at the negedge, the sampling edge counts as the first
        dueQ.push_back(cycle + expLatency);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic expectQuiet(input int n);
        repeat (n) begin
            @(negedge clk);
            checkValue({testName, " idle outValid"}, 128'(0), 128'(outValid));
        end
    endtask

    task automatic waitDrain(input int limit);
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                failRun($sformatf("Timeout in %s: %0d blocks never came out",
                                  testName, expQ.size()));
            end
        end
    endtask

    // Anything still in flight is dropped
    task automatic applyReset(input int n);
        Baud8GeneratorACC = 1'b1;
        inValid           = 1'b0;
        expQ.delete();
        dueQ.delete();
        expectQuiet(n);
        @(posedge clk);
        #1;
        Baud8GeneratorACC = 1'b0;
    endtask

    initial begin
        aesBlockT fipsKey;
        aesBlockT fipsPlain;
        int       gap;
        seed              = 32'he589;
        clk               = 1'b0;
        Baud8GeneratorACC = 1'b1;
        inValid           = 1'b0;
        plainText         = '0;
        cipherKey         = '0;
        fipsKey           = 128'h000102030405060708090a0b0c0d0e0f;
        fipsPlain         = 128'h00112233445566778899aabbccddeeff;

        testName = "powerOnReset";
        applyReset(10);

        testName = "quietAfterReset";
        expectQuiet(30);

        // Known answer from FIPS-197
        testName = "fipsVector";
        checkValue("fipsVector model", 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                   aesEncrypt(fipsPlain, fipsKey));
        sendBlock(fipsPlain, fipsKey);
        idle(1);
        waitDrain(expLatency + 3);

        testName = "backToBack";
        for (int i = 0; i < 30; i++) begin
            sendBlock(randomBlock(), randomBlock());
        end
        idle(1);
        waitDrain(expLatency + 3);

        testName = "randomGaps";
        for (int i = 0; i < 20; i++) begin
            sendBlock(randomBlock(), randomBlock());
            gap = $random(seed) & 7;
            idle(gap);
        end
        idle(1);
        waitDrain(expLatency + 3);

        testName = "resetInFlight";
        for (int i = 0; i < 8; i++) begin
            sendBlock(randomBlock(), randomBlock());
        end
        idle(5);
        applyReset(10);
        expectQuiet(25);
        for (int i = 0; i < 10; i++) begin
            sendBlock(randomBlock(), randomBlock());
        end
        idle(1);
        waitDrain(expLatency + 3);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
source/aesPkg.sv
source/aesSubBytes.sv
source/aesTableLookup.sv
source/aesKeyExpand.sv
source/aesRound.sv
source/aesFinalRound.sv
source/aesCipherTop.sv
dv/aesCipherTb.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the AES pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -j 0 -f filelist.f --top-module aesCipherTb -o aesSim \
    && ./obj_dir/aesSim 2>&1 | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// File: source/aesCipherTop.sv
`default_nettype none
`timescale 1ns/100ps

module aesCipherTop (
    input  logic             clk,
    input  logic             Baud8GeneratorACC,
    input  logic             inValid,
    input  aesPkg::aesBlockT plainText,
    input  aesPkg::aesBlockT cipherKey,
    output logic             outValid,
    output aesPkg::aesBlockT cipherText
);
    import aesPkg::*;

    aesBlockT                 whitenState;
    aesBlockT                 whitenKey;
    aesBlockT                 stateChain [numRounds];
    aesBlockT                 keyChain   [numRounds];
    aesBlockT                 roundKeys  [numRounds];
    logic [cipherLatency-1:0] validPipe;

    //////////////////////////////////////////////////
    // Initial AddRoundKey
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        whitenState <= plainText ^ cipherKey;
        whitenKey   <= cipherKey;
    end

    assign stateChain[0] = whitenState;
    assign keyChain[0]   = whitenKey;

    //////////////////////////////////////////////////
    // Key schedule, one step per round
    //////////////////////////////////////////////////

    for (genvar i = 0; i < numRounds; i++) begin : gKeyStep
        if (i < numRounds - 1) begin : gChain
            aesKeyExpand u_aesKeyExpand (
                .clk      (clk),
                .rcon     (roundConst[i]),
                .keyIn    (keyChain[i]),
                .roundKey (roundKeys[i]),
                .keyOut   (keyChain[i+1])
            );
        end else begin : gLast
            // Last step only supplies the final round key
            aesKeyExpand u_aesKeyExpand (
                .clk      (clk),
                .rcon     (roundConst[i]),
                .keyIn    (keyChain[i]),
                .roundKey (roundKeys[i]),
                .keyOut   ()
            );
        end
    end

    //////////////////////////////////////////////////
    // Round datapath
    //////////////////////////////////////////////////

    for (genvar i = 0; i < numRounds - 1; i++) begin : gRound
        aesRound u_aesRound (
            .clk      (clk),
            .stateIn  (stateChain[i]),
            .roundKey (roundKeys[i]),
            .stateOut (stateChain[i+1])
        );
    end

    aesFinalRound u_aesFinalRound (
        .clk      (clk),
        .stateIn  (stateChain[numRounds-1]),
        .roundKey (roundKeys[numRounds-1]),
        .stateOut (cipherText)
    );

    // Valid strobe travels alongside the data
    always_ff @(posedge clk or posedge Baud8GeneratorACC) begin
        if (Baud8GeneratorACC) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[cipherLatency-2:0], inValid};
        end
    end

    assign outValid = validPipe[cipherLatency-1];

    // Nothing comes out while the pipeline is held in reset
    assert property (@(posedge clk) Baud8GeneratorACC |-> !outValid)
        else $error("outValid high during reset");

    // One output per input, cipherLatency cycles later, unless a reset hit the window
    assert property (@(posedge clk) disable iff (Baud8GeneratorACC)
        1'b1 |-> ##cipherLatency (outValid == $past(inValid, cipherLatency)))
        else $error("outValid does not follow inValid");

    assert property (@(posedge clk) disable iff (Baud8GeneratorACC)
        outValid |-> !$isunknown(cipherText))
        else $error("cipherText unknown while outValid");

endmodule

`default_nettype wire

// File: source/aesFinalRound.sv
`default_nettype none
`timescale 1ns/100ps

module aesFinalRound (
    input  logic             clk,
    input  aesPkg::aesBlockT stateIn,
    input  aesPkg::aesBlockT roundKey,
    output aesPkg::aesBlockT stateOut
);
    import aesPkg::*;

    aesWordT s  [4];
    aesWordT k  [4];
    aesWordT sw [4];
    aesWordT z  [4];

    assign {s[0], s[1], s[2], s[3]} = stateIn;
    assign {k[0], k[1], k[2], k[3]} = roundKey;

    for (genvar c = 0; c < 4; c++) begin : gColumn
        aesSubBytes u_aesSubBytes (
            .clk     (clk),
            .inWord  (s[c]),
            .outWord (sw[c])
        );

        // No MixColumns here, bytes are only moved along the diagonal
        assign z[c] = {sw[c][31:24], sw[(c+1)%4][23:16],
                       sw[(c+2)%4][15:8], sw[(c+3)%4][7:0]} ^ k[c];
    end

    always_ff @(posedge clk) begin
        stateOut <= {z[0], z[1], z[2], z[3]};
    end

endmodule

`default_nettype wire

// File: source/aesKeyExpand.sv
`default_nettype none
`timescale 1ns/100ps

module aesKeyExpand (
    input  logic             clk,
    input  aesPkg::aesByteT  rcon,
    input  aesPkg::aesBlockT keyIn,
    output aesPkg::aesBlockT roundKey,
    output aesPkg::aesBlockT keyOut
);
    import aesPkg::*;

    aesWordT  w0, w1, w2, w3;
    aesWordT  v0, v1, v2, v3;
    aesWordT  r0, r1, r2, r3;
    aesWordT  subRot;
    aesBlockT nextKey;

    assign {w0, w1, w2, w3} = keyIn;

    // Round constant goes into the top byte of the first word
    assign v0 = {w0[31:24] ^ rcon, w0[23:0]};
    assign v1 = v0 ^ w1;
    assign v2 = v1 ^ w2;
    assign v3 = v2 ^ w3;

    // First stage, XOR chain
    always_ff @(posedge clk) begin
        r0 <= v0;
        r1 <= v1;
        r2 <= v2;
        r3 <= v3;
    end

    // First stage in parallel, RotWord then SubWord
    aesSubBytes u_aesSubBytes (
        .clk     (clk),
        .inWord  ({w3[23:0], w3[31:24]}),
        .outWord (subRot)
    );

    // SubWord result folds into every word of the chain
    assign nextKey = {r0 ^ subRot, r1 ^ subRot, r2 ^ subRot, r3 ^ subRot};

    // Round key is needed one cycle after keyIn
    assign roundKey = nextKey;

    // Second stage feeds the next key step
    always_ff @(posedge clk) begin
        keyOut <= nextKey;
    end

endmodule

`default_nettype wire

// File: source/aesPkg.sv
`default_nettype none

package aesPkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [127:0] aesBlockT;
    typedef logic [31:0]  aesWordT;
    typedef logic [7:0]   aesByteT;

    //////////////////////////////////////////////////
    // Pipeline shape
    //////////////////////////////////////////////////

    localparam int numRounds    = 10;
    localparam int stageLatency = 2;

    // Whitening register plus two cycles per round
    localparam int cipherLatency = 1 + stageLatency * numRounds;

    // Key schedule constants, one per key step
    localparam aesByteT roundConst [numRounds] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    //////////////////////////////////////////////////
    // GF(2^8) arithmetic, modulus x^8+x^4+x^3+x+1
    //////////////////////////////////////////////////

    function automatic aesByteT xtime(input aesByteT a);
        aesByteT shifted;
        shifted = {a[6:0], 1'b0};
        return a[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

    // Shift-and-add multiply
    function automatic aesByteT gfMul(input aesByteT a, input aesByteT b);
        aesByteT acc;
        aesByteT term;
        acc  = '0;
        term = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // Inverse as a^254, so zero maps to zero
    function automatic aesByteT gfInverse(input aesByteT a);
        aesByteT power;
        aesByteT result;
        power  = a;
        result = 8'h01;
        for (int i = 1; i < 8; i++) begin
            power  = gfMul(power, power);
            result = gfMul(result, power);
        end
        return result;
    endfunction

    // S-box: field inverse followed by the affine map
    function automatic aesByteT sBox(input aesByteT a);
        aesByteT inv;
        inv = gfInverse(a);
        return inv
             ^ {inv[6:0], inv[7]}
             ^ {inv[5:0], inv[7:6]}
             ^ {inv[4:0], inv[7:5]}
             ^ {inv[3:0], inv[7:4]}
             ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

// File: source/aesRound.sv
`default_nettype none
`timescale 1ns/100ps

module aesRound (
    input  logic             clk,
    input  aesPkg::aesBlockT stateIn,
    input  aesPkg::aesBlockT roundKey,
    output aesPkg::aesBlockT stateOut
);
    import aesPkg::*;

    aesWordT s [4];
    aesWordT k [4];
    aesWordT p [4][4];
    aesWordT z [4];

    assign {s[0], s[1], s[2], s[3]} = stateIn;
    assign {k[0], k[1], k[2], k[3]} = roundKey;

    // SubBytes and MixColumns weights, first cycle
    for (genvar c = 0; c < 4; c++) begin : gLookup
        aesTableLookup u_aesTableLookup (
            .clk       (clk),
            .stateWord (s[c]),
            .p0        (p[c][0]),
            .p1        (p[c][1]),
            .p2        (p[c][2]),
            .p3        (p[c][3])
        );
    end

    // Taking row r from column c+r is ShiftRows
    for (genvar c = 0; c < 4; c++) begin : gColumn
        assign z[c] = p[c][0] ^ p[(c+1)%4][1] ^ p[(c+2)%4][2] ^ p[(c+3)%4][3] ^ k[c];
    end

    always_ff @(posedge clk) begin
        stateOut <= {z[0], z[1], z[2], z[3]};
    end

endmodule

`default_nettype wire

// File: source/aesSubBytes.sv
`default_nettype none
`timescale 1ns/100ps

module aesSubBytes (
    input  logic            clk,
    input  aesPkg::aesWordT inWord,
    output aesPkg::aesWordT outWord
);
    import aesPkg::*;

    // One S-box per byte lane, registered
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            outWord[8*k +: 8] <= sBox(inWord[8*k +: 8]);
        end
    end

endmodule

`default_nettype wire

// File: source/aesTableLookup.sv
`default_nettype none
`timescale 1ns/100ps

module aesTableLookup (
    input  logic            clk,
    input  aesPkg::aesWordT stateWord,
    output aesPkg::aesWordT p0,
    output aesPkg::aesWordT p1,
    output aesPkg::aesWordT p2,
    output aesPkg::aesWordT p3
);
    import aesPkg::*;

    aesWordT column [4];

    for (genvar k = 0; k < 4; k++) begin : gByte
        aesByteT subNext;
        aesByteT subReg;
        aesByteT dblReg;

        // Byte 0 sits in the top lane
        assign subNext = sBox(stateWord[31-8*k -: 8]);

        always_ff @(posedge clk) begin
            subReg <= subNext;
            dblReg <= xtime(subNext);
        end

        // MixColumns weights 2, 1, 1, 3
        assign column[k] = {dblReg, subReg, subReg, dblReg ^ subReg};
    end

    // Each byte's contribution rotated down to its row
    assign p0 = column[0];
    assign p1 = {column[1][7:0],  column[1][31:8]};
    assign p2 = {column[2][15:0], column[2][31:16]};
    assign p3 = {column[3][23:0], column[3][31:24]};

endmodule

`default_nettype wire
